//--- logic/stream_defines.svh
`ifndef STREAM_DEFINES_SVH
`define STREAM_DEFINES_SVH

// --------------------------------------------------
// Sample word and buffer geometry
// --------------------------------------------------

// Width of one captured sample word
`define STREAM_WIDTH 16

// Address bits of the sample buffer, 16 words
`define STREAM_WBITS 4

// --------------------------------------------------
// Readout window
// --------------------------------------------------

// First and last address replayed on each pass
`define STREAM_START 2
`define STREAM_LAST 13

// Address increment per accepted read
`define STREAM_STEP 1

// Depth of the consumer buffer, also the reader's initial credits
`define STREAM_CREDITS 4

`endif

//--- logic/stream_pkg.sv
package stream_pkg;

   // --------------------------------------------------
   // Reader FSM
   // --------------------------------------------------

   // Idle until enabled, then stream against credits
   typedef enum logic {
      IDLE   = 1'b0,
      STREAM = 1'b1
   } reader_state_e;

   // --------------------------------------------------
   // Bus operations
   // --------------------------------------------------

   // Encoding matches the we line of the bus
   typedef enum logic {
      BUS_READ  = 1'b0,
      BUS_WRITE = 1'b1
   } bus_op_e;

endpackage

//--- logic/wb_bus_if.sv
`timescale 1ns/1ps
`include "stream_defines.svh"

interface wb_bus_if;

   // Request side, driven by the master
   logic                     cyc;
   logic                     stb;
   logic                     we;
   logic                     bst;
   logic [`STREAM_WBITS-1:0] adr;
   logic [`STREAM_WIDTH-1:0] dat_w;

   // Response side, driven by the slave
   logic                     ack;
   logic                     wat;
   logic [`STREAM_WIDTH-1:0] dat_r;

   // Window wrap flag, valid together with ack
   logic                     wrp;

   // --------------------------------------------------
   // Modports
   // --------------------------------------------------

   modport master (
      output cyc,
      output stb,
      output we,
      output bst,
      output adr,
      output dat_w,
      input  ack,
      input  wat,
      input  dat_r,
      input  wrp
   );

   modport slave (
      input  cyc,
      input  stb,
      input  we,
      input  bst,
      input  adr,
      input  dat_w,
      output ack,
      output wat,
      output dat_r,
      output wrp
   );

endinterface

//--- logic/block_sram.sv
`timescale 1ns/1ps
`include "stream_defines.svh"

module block_sram (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     wr_en_i,
   input  logic [`STREAM_WBITS-1:0] wr_adr_i,
   input  logic [`STREAM_WIDTH-1:0] wr_dat_i,
   wb_bus_if.slave                  bus_s
);

   localparam int DEPTH = 1 << `STREAM_WBITS;

   // Sample storage
   logic [`STREAM_WIDTH-1:0] mem [DEPTH];

   // Bus access taken this cycle
   logic                     bus_take;
   logic                     ack_q;
   logic [`STREAM_WIDTH-1:0] rd_q;

   // --------------------------------------------------
   // Port arbitration
   // --------------------------------------------------

   // Capture owns the single port, bus waits
   assign bus_s.wat = wr_en_i;

   // Pipelined acceptance, no wait means taken
   assign bus_take = bus_s.cyc && bus_s.stb && !wr_en_i;

   // --------------------------------------------------
   // Memory array
   // --------------------------------------------------

   always_ff @(posedge clk_i) begin
      if (wr_en_i) begin
         mem[wr_adr_i] <= wr_dat_i;
      end else if (bus_take && bus_s.we) begin
         mem[bus_s.adr] <= bus_s.dat_w;
      end
      // Read word lands one cycle after acceptance
      if (bus_take && !bus_s.we) begin
         rd_q <= mem[bus_s.adr];
      end
   end

   // One acknowledge per accepted access
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= bus_take;
      end
   end

   assign bus_s.ack   = ack_q;
   assign bus_s.dat_r = rd_q;

   // Plain memory has no window, so never wraps
   assign bus_s.wrp   = 1'b0;

endmodule

//--- logic/wb_stream.sv
`timescale 1ns/1ps
`include "stream_defines.svh"

module wb_stream
   import stream_pkg::*;
#(
   parameter int unsigned START = 0,
   parameter int unsigned LAST  = (1 << `STREAM_WBITS) - 1,
   parameter int unsigned STEP  = 1
) (
   input  logic    clk_i,
   input  logic    rst_i,
   wb_bus_if.slave  s_bus,
   wb_bus_if.master m_bus
);

   localparam int AW = `STREAM_WBITS;

   // Window bounds at address width
   localparam logic [AW-1:0] START_ADR = AW'(START);
   localparam logic [AW-1:0] LAST_ADR  = AW'(LAST);
   localparam logic [AW-1:0] STEP_ADR  = AW'(STEP);

   bus_op_e       op;
   logic          inc;
   logic          at_last;
   logic [AW-1:0] adr_q;
   logic [AW-1:0] adr_d;
   logic          wrapped_q;

   // --------------------------------------------------
   // Pass-through of all lines except address
   // --------------------------------------------------
   assign m_bus.cyc   = s_bus.cyc;
   assign m_bus.stb   = s_bus.stb;
   assign m_bus.we    = s_bus.we;
   assign m_bus.bst   = s_bus.bst;
   assign m_bus.dat_w = s_bus.dat_w;
   assign m_bus.adr   = adr_q;

   assign s_bus.ack   = m_bus.ack;
   assign s_bus.wat   = m_bus.wat;
   assign s_bus.dat_r = m_bus.dat_r;

   // Wrap strobe rides back with the ack of the last word
   assign s_bus.wrp   = wrapped_q;

   // --------------------------------------------------
   // Address generation
   // --------------------------------------------------
   assign op      = s_bus.we ? BUS_WRITE : BUS_READ;

   // Accepted stream read, write cycles leave the pointer alone
   assign inc     = m_bus.cyc && m_bus.stb && !m_bus.wat && (op == BUS_READ);
   assign at_last = (adr_q == LAST_ADR);
   assign adr_d   = at_last ? START_ADR : adr_q + STEP_ADR;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         adr_q     <= START_ADR;
         wrapped_q <= 1'b0;
      end else begin
         if (inc) begin
            adr_q <= adr_d;
         end
         // One-cycle strobe for the access that hit LAST
         wrapped_q <= inc && at_last;
      end
   end

endmodule

//--- logic/stream_reader.sv
`timescale 1ns/1ps
`include "stream_defines.svh"

module stream_reader
   import stream_pkg::*;
(
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     enable_i,
   input  logic                     credit_i,
   wb_bus_if.master                 req_m,
   input  logic                     wrapped_i,
   output logic [`STREAM_WIDTH-1:0] data_o,
   output logic                     valid_o,
   output logic                     last_o
);

   localparam int CW = $clog2(`STREAM_CREDITS + 1);
   localparam logic [CW-1:0] MAX_CREDITS = CW'(`STREAM_CREDITS);

   reader_state_e state_q;
   reader_state_e state_d;
   bus_op_e       req_op;

   logic [CW-1:0] credit_q;
   logic          take;
   logic          have_credit;

   // --------------------------------------------------
   // FSM
   // --------------------------------------------------

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (enable_i) begin
               state_d = STREAM;
            end
         end
         STREAM: begin
            // Stop issuing, words in flight still arrive
            if (!enable_i) begin
               state_d = IDLE;
            end
         end
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // --------------------------------------------------
   // Credit counter
   // --------------------------------------------------

   assign have_credit = (credit_q != '0);

   // Request accepted by the slave this cycle
   assign take = req_m.cyc && req_m.stb && !req_m.wat;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         credit_q <= MAX_CREDITS;
      end else begin
         case ({take, credit_i})
            2'b10: credit_q <= credit_q - 1'b1;
            // Saturate at consumer depth
            2'b01: if (credit_q != MAX_CREDITS) credit_q <= credit_q + 1'b1;
            default: credit_q <= credit_q;
         endcase
      end
   end

   // --------------------------------------------------
   // Bus request
   // --------------------------------------------------

   // Read-only stream
   assign req_op      = BUS_READ;
   assign req_m.we    = (req_op == BUS_WRITE);
   assign req_m.bst   = 1'b0;
   assign req_m.dat_w = '0;

   // Address comes from the generator downstream
   assign req_m.adr   = '0;

   assign req_m.cyc   = (state_q == STREAM);
   assign req_m.stb   = (state_q == STREAM) && have_credit;

   // Each ack is one word for the consumer
   assign valid_o = req_m.ack;
   assign data_o  = req_m.dat_r;
   assign last_o  = req_m.ack && wrapped_i;

endmodule

//--- logic/stream_readout_top.sv
`timescale 1ns/1ps
`include "stream_defines.svh"

module stream_readout_top
   import stream_pkg::*;
(
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     enable_i,
   input  logic                     credit_i,
   input  logic                     wr_en_i,
   input  logic [`STREAM_WBITS-1:0] wr_adr_i,
   input  logic [`STREAM_WIDTH-1:0] wr_dat_i,
   output logic [`STREAM_WIDTH-1:0] data_o,
   output logic                     valid_o,
   output logic                     last_o
);

   // --------------------------------------------------
   // Buses
   // --------------------------------------------------

   // Reader to address generator
   wb_bus_if req_bus ();

   // Address generator to memory
   wb_bus_if mem_bus ();

   // --------------------------------------------------
   // Instances
   // --------------------------------------------------

   stream_reader u_reader (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .enable_i  (enable_i),
      .credit_i  (credit_i),
      .req_m     (req_bus.master),
      .wrapped_i (req_bus.wrp),
      .data_o    (data_o),
      .valid_o   (valid_o),
      .last_o    (last_o)
   );

   wb_stream #(
      .START (`STREAM_START),
      .LAST  (`STREAM_LAST),
      .STEP  (`STREAM_STEP)
   ) u_stream (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .s_bus (req_bus.slave),
      .m_bus (mem_bus.master)
   );

   // Capture port owns the memory whenever it writes
   block_sram u_sram (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .wr_en_i  (wr_en_i),
      .wr_adr_i (wr_adr_i),
      .wr_dat_i (wr_dat_i),
      .bus_s    (mem_bus.slave)
   );

endmodule

//--- verification/stream_readout_checker.sv
`timescale 1ns/1ps
`include "stream_defines.svh"

module stream_readout_checker #(
   parameter int CW = $clog2(`STREAM_CREDITS + 1)
) (
   input logic          clk_i,
   input logic          rst_i,
   input logic          take_i,
   input logic [CW-1:0] credit_cnt_i,
   input logic          valid_i
);

   // --------------------------------------------------
   // Credit flow control
   // --------------------------------------------------

   // A request may only be accepted with a credit in hand
   credit_on_take: assert property (
      @(posedge clk_i) disable iff (rst_i)
      take_i |-> (credit_cnt_i != '0)
   ) else $error("read request accepted with zero credits");

   // Counter saturates at the consumer depth
   credit_saturates: assert property (
      @(posedge clk_i) disable iff (rst_i)
      credit_cnt_i <= CW'(`STREAM_CREDITS)
   ) else $error("credit count above consumer depth");

   // --------------------------------------------------
   // Reset and bus timing
   // --------------------------------------------------

   // No word leaves in the first cycle out of reset
   valid_after_reset: assert property (
      @(posedge clk_i)
      $fell(rst_i) |-> !valid_i
   ) else $error("valid_o high in the first cycle after reset");

   // Ack follows acceptance by exactly one cycle, never otherwise
   ack_one_cycle: assert property (
      @(posedge clk_i) disable iff (rst_i)
      valid_i == $past(take_i)
   ) else $error("ack not exactly one cycle after acceptance");

endmodule

//--- verification/stream_readout_tb.sv
`timescale 1ns/1ps
`include "stream_defines.svh"

module stream_readout_tb;

   localparam int AW       = `STREAM_WBITS;
   localparam int DEPTH    = 1 << AW;
   localparam int PASS_LEN = (`STREAM_LAST - `STREAM_START) / `STREAM_STEP + 1;
   localparam int NWR      = 3;
   localparam int NPAT     = DEPTH + PASS_LEN + 3 * NWR;
   localparam int PW       = $clog2(NPAT);
   localparam int TIMEOUT  = 500;

   localparam logic [AW-1:0] START_ADR = AW'(`STREAM_START);
   localparam logic [AW-1:0] LAST_ADR  = AW'(`STREAM_LAST);
   localparam logic [AW-1:0] STEP_ADR  = AW'(`STREAM_STEP);

   logic                     clk_i    = 1'b0;
   logic                     credit_i = 1'b0;
   logic                     rst_i;
   logic                     enable_i;
   logic                     wr_en_i;
   logic [AW-1:0]            wr_adr_i;
   logic [`STREAM_WIDTH-1:0] wr_dat_i;
   logic [`STREAM_WIDTH-1:0] data_o;
   logic                     valid_o;
   logic                     last_o;

   // Pattern file image and the buffer mirror
   logic [`STREAM_WIDTH-1:0] pat   [NPAT];
   logic [`STREAM_WIDTH-1:0] model [DEPTH];
   logic [`STREAM_WIDTH-1:0] rx_q  [$];
   logic [AW-1:0]            exp_adr = START_ADR;
   logic [15:0]              lfsr = 16'd58885;
   int                       words_seen;
   int                       rx_total;
   int                       ret_total;
   int                       drain_wait;
   int                       errors;
   int                       checks;
   int                       tests;
   bit                       withhold;
   bit                       hold;
   bit                       in_reset;

   stream_readout_top dut0 (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .enable_i (enable_i),
      .credit_i (credit_i),
      .wr_en_i  (wr_en_i),
      .wr_adr_i (wr_adr_i),
      .wr_dat_i (wr_dat_i),
      .data_o   (data_o),
      .valid_o  (valid_o),
      .last_o   (last_o)
   );

   bind stream_reader stream_readout_checker chk0 (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .take_i       (take),
      .credit_cnt_i (credit_q),
      .valid_i      (valid_o)
   );

   always #5 clk_i = ~clk_i;

   // --------------------------------------------------
   // Helpers
   // --------------------------------------------------

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // One LFSR step per bit taken
   function automatic int random_bits(input int n);
      int v;
      v = 0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v = (v << 1) | int'(lfsr[0]);
      end
      return v;
   endfunction

   function automatic logic [`STREAM_WIDTH-1:0] pat_word(input int i);
      return pat[PW'(i)];
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic tick(input int n);
      repeat (n) begin
         @(posedge clk_i);
         #1;
      end
   endtask

   task automatic wait_words(input int n, input string what);
      int target;
      int t;
      target = words_seen + n;
      t = 0;
      while (words_seen < target && t < TIMEOUT) begin
         tick(1);
         t++;
      end
      if (words_seen < target) begin
         errors++;
         $display("Timeout waiting for %s, %0d words short", what, target - words_seen);
      end
   endtask

   // Waits for n cycles in a row without a word
   task automatic wait_quiet(input int n);
      int idle;
      int t;
      idle = 0;
      t = 0;
      while (idle < n && t < TIMEOUT) begin
         tick(1);
         idle = valid_o ? 0 : idle + 1;
         t++;
      end
      if (idle < n) begin
         errors++;
         $display("Timeout, stream kept running after enable fell");
      end
   endtask

   task automatic capture_write(input logic [AW-1:0] adr, input logic [`STREAM_WIDTH-1:0] dat);
      wr_en_i  = 1'b1;
      wr_adr_i = adr;
      wr_dat_i = dat;
      tick(1);
      wr_en_i  = 1'b0;
   endtask

   task automatic apply_reset();
      rst_i    = 1'b1;
      enable_i = 1'b0;
      tick(10);
      rst_i    = 1'b0;
   endtask

   task automatic finish_test(input string name, input int err_before);
      tests++;
      $display("test %0d %s: %0d errors", tests, name, errors - err_before);
   endtask

   // --------------------------------------------------
   // Consumer and monitor
   // --------------------------------------------------

   // Drains one buffered word after a random delay of 0 to 3 cycles
   always begin
      @(posedge clk_i);
      hold     = withhold;
      in_reset = rst_i;
      #1;
      credit_i = 1'b0;
      if (in_reset) begin
         ret_total  = 0;
         drain_wait = 0;
      end else if (!hold && rx_total > ret_total) begin
         if (drain_wait == 0) begin
            credit_i   = 1'b1;
            ret_total++;
            drain_wait = random_bits(2);
         end else begin
            drain_wait--;
         end
      end
   end

   // Words are checked against the mirror at the falling edge
   always @(negedge clk_i) begin
      if (rst_i) begin
         exp_adr  = START_ADR;
         rx_total = 0;
      end else begin
         if (valid_o) begin
            check_value("data_o", 32'(data_o), 32'(model[exp_adr]));
            check_value("last_o", 32'(last_o), 32'(exp_adr == LAST_ADR));
            rx_q.push_back(data_o);
            exp_adr = (exp_adr == LAST_ADR) ? START_ADR : exp_adr + STEP_ADR;
            words_seen++;
            rx_total++;
            check_value("rx_over_credit", 32'(rx_total > ret_total + `STREAM_CREDITS), 32'd0);
         end
         // Capture write lands after the word of this cycle was read
         if (wr_en_i) begin
            model[wr_adr_i] = wr_dat_i;
         end
      end
   end

   // --------------------------------------------------
   // Test sequence
   // --------------------------------------------------

   initial begin
      int e;
      int base;
      int idx;
      rst_i    = 1'b1;
      enable_i = 1'b0;
      wr_en_i  = 1'b0;
      wr_adr_i = '0;
      wr_dat_i = '0;
      $readmemh("verification/stream_readout_patterns.txt", pat);
      apply_reset();

      // Load the buffer, then three full passes in order
      e = errors;
      for (int a = 0; a < DEPTH; a++) begin
         capture_write(AW'(a), pat_word(a));
      end
      base = rx_q.size();
      enable_i = 1'b1;
      wait_words(3 * PASS_LEN, "three passes");
      for (int i = 0; i < 3 * PASS_LEN && base + i < rx_q.size(); i++) begin
         check_value("pass_word", 32'(rx_q[base + i]), 32'(pat_word(DEPTH + i % PASS_LEN)));
      end
      finish_test("order and pass marker", e);

      // Withhold all credits until every outstanding one is spent
      e = errors;
      withhold = 1'b1;
      tick(30);
      check_value("words_held", 32'(rx_total - ret_total), 32'(`STREAM_CREDITS));
      withhold = 1'b0;
      wait_words(PASS_LEN, "resume after credit hold");
      finish_test("credit flow control", e);

      // Capture writes at given word offsets while streaming
      e = errors;
      base = words_seen;
      for (int w = 0; w < NWR; w++) begin
         idx = DEPTH + PASS_LEN + 3 * w;
         wait_words(int'(pat_word(idx)) - (words_seen - base), "capture offset");
         capture_write(AW'(pat_word(idx + 1)), pat_word(idx + 2));
      end
      wait_words(2 * PASS_LEN, "stream after captures");
      finish_test("capture priority", e);

      // Stop, resume, then reset in the middle of a pass
      e = errors;
      enable_i = 1'b0;
      wait_quiet(4);
      base = words_seen;
      tick(8);
      check_value("words_after_stop", 32'(words_seen - base), 32'd0);
      enable_i = 1'b1;
      wait_words(5, "resume after stop");
      apply_reset();
      tick(6);
      check_value("words_after_reset", 32'(rx_total), 32'd0);
      enable_i = 1'b1;
      wait_words(PASS_LEN, "pass after reset");
      enable_i = 1'b0;
      finish_test("stop and reset", e);

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

//--- verification/stream_readout_patterns.txt
// Lines 1-4: sample buffer, 16 words from address 0, four per line
// Lines 5-7: expected pass from window start to window last, 12 words
// Lines 8-10: capture writes as word offset, address, data
0A50 1B61 2C72 3D83
4E94 5FA5 60B6 71C7
82D8 93E9 A4FA B50B
C61C D72D E83E F94F
2C72 3D83 4E94 5FA5
60B6 71C7 82D8 93E9
A4FA B50B C61C D72D
0003 0009 BEEF
0007 000C CAFE
000A 0004 0123

//--- stream_readout_top.f
+incdir+logic
logic/stream_pkg.sv
logic/wb_bus_if.sv
logic/block_sram.sv
logic/wb_stream.sv
logic/stream_reader.sv
logic/stream_readout_top.sv
verification/stream_readout_checker.sv
verification/stream_readout_tb.sv

//--- Makefile
TOP = stream_readout_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f stream_readout_top.f --top-module $(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG) || ! grep -q "Testbench passed" $(LOG); then \
		echo "Simulation result: FAIL"; \
		exit 1; \
	else \
		echo "Simulation result: PASS"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
